// File: verilog/mem_cfg_pkg.sv
package mem_cfg_pkg;

  localparam int width      = 16;
  localparam int num_vbnk   = 4;
  localparam int bit_vbnk   = 2;
  localparam int num_pbnk   = 5;                // one spare over the virtual count
  localparam int bit_pbnk   = 3;
  localparam int num_vrow   = 16;
  localparam int bit_vrow   = 4;
  localparam int bit_addr   = 6;
  localparam int rd_latency = 2;                // read strobe to rd_vld

  // init FSM encoding
  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_sweep = 2'd1;
  localparam logic [1:0] st_run   = 2'd2;

  typedef struct packed {
    logic [bit_vbnk-1:0] vbank;                 // upper bits pick the vbank
    logic [bit_vrow-1:0] row;
  } addr_fields_t;

  // user address, flat or split
  typedef union packed {
    logic [bit_addr-1:0] flat;
    addr_fields_t        fields;
  } mem_addr_u;

endpackage

// File: verilog/mem_port_pkg.sv
package mem_port_pkg;

  import mem_cfg_pkg::*;

  typedef struct packed {
    logic             en;
    mem_addr_u        addr;
    logic [width-1:0] data;
  } wr_req_t;

  typedef struct packed {
    logic      en;
    mem_addr_u addr;
  } rd_req_t;

  // one access to one physical bank
  typedef struct packed {
    logic                en;
    logic                we;                    // low means read
    logic [bit_vrow-1:0] row;
    logic [width-1:0]    data;
  } bank_cmd_t;

  typedef bank_cmd_t [num_pbnk-1:0] bank_cmd_vec_t;

  typedef struct packed {
    logic [num_vbnk-1:0][bit_pbnk-1:0] pbnk;    // home bank per vbank
    logic [bit_pbnk-1:0]               free;    // spare bank of this row
  } row_map_t;

endpackage

// File: verilog/bank_sram.sv
module bank_sram
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  logic             clk,
  input  bank_cmd_t        cmd,
  output logic [width-1:0] rdata
);

  logic [width-1:0] mem [num_vrow];

  // single port, so one access per cycle
  always_ff @(posedge clk) begin
    if (cmd.en) begin
      if (cmd.we) begin
        mem[cmd.row] <= cmd.data;
      end else begin
        rdata <= mem[cmd.row];                  // held until the next read
      end
    end
  end

endmodule

// File: verilog/row_sweep_counter.sv
module row_sweep_counter
  import mem_cfg_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  output logic [bit_vrow-1:0] row,
  output logic                last
);

  logic running;

  always_ff @(posedge clk) begin
    if (rst) begin
      row     <= '0;
      running <= 1'b0;
    end else if (start) begin
      row     <= '0;
      running <= 1'b1;
    end else if (running) begin
      if (last) begin
        running <= 1'b0;                        // stop after the final row
      end else begin
        row <= row + 1'b1;
      end
    end
  end

  assign last = running && (row == bit_vrow'(num_vrow - 1));

endmodule

// File: verilog/init_ctrl.sv
module init_ctrl
  import mem_cfg_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic last,
  output logic start,
  output logic init_busy,
  output logic ready
);

  logic [1:0] state;
  logic [1:0] state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:  state_nxt = st_sweep;
      st_sweep: if (last) state_nxt = st_run;
      st_run:   state_nxt = st_run;             // stays here until reset
      default:  state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      ready <= 1'b0;
    end else begin
      state <= state_nxt;
      ready <= (state_nxt == st_run);
    end
  end

  assign start     = (state == st_idle);
  assign init_busy = (state == st_sweep);

endmodule

// File: verilog/remap_table.sv
module remap_table
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                init_busy,
  input  logic [bit_vrow-1:0] sweep_row,
  input  wr_req_t             wr,
  input  rd_req_t             rd,
  output bank_cmd_vec_t       bank_cmd,
  output logic [bit_pbnk-1:0] rd_pbnk
);

  row_map_t            map_q [num_vrow];
  row_map_t            rd_map;
  row_map_t            wr_map;
  row_map_t            wr_map_nxt;
  row_map_t            ident_map;
  mem_addr_u           rd_addr;
  mem_addr_u           wr_addr;
  logic [bit_pbnk-1:0] wr_home;
  logic [bit_pbnk-1:0] wr_pbnk;
  logic                redirect;

  assign rd_addr = rd.addr;
  assign wr_addr = wr.addr;

  assign rd_map  = map_q[rd_addr.fields.row];
  assign wr_map  = map_q[wr_addr.fields.row];
  assign rd_pbnk = rd_map.pbnk[rd_addr.fields.vbank];
  assign wr_home = wr_map.pbnk[wr_addr.fields.vbank];

  // read owns the bank, write moves to the spare of its row
  assign redirect = wr.en && rd.en && (wr_home == rd_pbnk);
  assign wr_pbnk  = redirect ? wr_map.free : wr_home;

  always_comb begin
    wr_map_nxt = wr_map;
    wr_map_nxt.pbnk[wr_addr.fields.vbank] = wr_map.free;
    wr_map_nxt.free = wr_home;                  // old home becomes the spare
  end

  always_comb begin
    for (int v = 0; v < num_vbnk; v++) begin
      ident_map.pbnk[v] = bit_pbnk'(v);
    end
    ident_map.free = bit_pbnk'(num_vbnk);       // last physical bank
  end

  always_comb begin
    bank_cmd = '0;
    for (int p = 0; p < num_pbnk; p++) begin
      if (rd.en && (rd_pbnk == bit_pbnk'(p))) begin
        bank_cmd[p].en  = 1'b1;
        bank_cmd[p].we  = 1'b0;
        bank_cmd[p].row = rd_addr.fields.row;
      end
      if (wr.en && (wr_pbnk == bit_pbnk'(p))) begin
        bank_cmd[p].en   = 1'b1;
        bank_cmd[p].we   = 1'b1;
        bank_cmd[p].row  = wr_addr.fields.row;
        bank_cmd[p].data = wr.data;
      end
    end
  end

  // table is written by the sweep, then only by redirected writes
  always_ff @(posedge clk) begin
    if (init_busy) begin
      map_q[sweep_row] <= ident_map;
    end else if (redirect && !rst) begin
      map_q[wr_addr.fields.row] <= wr_map_nxt;
    end
  end

endmodule

// File: verilog/bank_array.sv
module bank_array
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  bank_cmd_vec_t       bank_cmd,
  input  logic [bit_pbnk-1:0] rd_pbnk,
  input  logic                rd_en,
  output logic                rd_vld,
  output logic [width-1:0]    rd_data
);

  logic [width-1:0]      bank_rdata [num_pbnk];
  logic [rd_latency-1:0] vld_pipe;
  logic [bit_pbnk-1:0]   rd_pbnk_q;

  for (genvar p = 0; p < num_pbnk; p++) begin : g_bank
    bank_sram u_bank_sram (
      .clk   (clk),
      .cmd   (bank_cmd[p]),
      .rdata (bank_rdata[p])
    );
  end

  // strobe walks alongside the bank access
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[rd_latency-2:0], rd_en};
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pbnk_q <= rd_pbnk;                     // which bank answers next cycle
    end
    if (vld_pipe[0]) begin
      rd_data <= bank_rdata[rd_pbnk_q];
    end
  end

  assign rd_vld = vld_pipe[rd_latency-1];

endmodule

// File: verilog/mem_1r1w_top.sv
module mem_1r1w_top
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  output logic             ready,
  input  wr_req_t          wr,
  input  rd_req_t          rd,
  output logic             rd_vld,
  output logic [width-1:0] rd_data
);

  logic                start;
  logic                init_busy;
  logic                last;
  logic [bit_vrow-1:0] sweep_row;
  logic [bit_pbnk-1:0] rd_pbnk;
  logic                rd_en;
  wr_req_t             wr_m;
  rd_req_t             rd_m;
  bank_cmd_vec_t       bank_cmd;

  // requests are dropped until the table is built
  assign rd_en = rd.en && ready;
  assign rd_m  = '{en: rd_en, addr: rd.addr};
  assign wr_m  = '{en: wr.en && ready, addr: wr.addr, data: wr.data};

  init_ctrl u_init_ctrl (
    .clk       (clk),
    .rst       (rst),
    .last      (last),
    .start     (start),
    .init_busy (init_busy),
    .ready     (ready)
  );

  row_sweep_counter u_row_sweep_counter (
    .clk   (clk),
    .rst   (rst),
    .start (start),
    .row   (sweep_row),
    .last  (last)
  );

  remap_table u_remap_table (
    .clk       (clk),
    .rst       (rst),
    .init_busy (init_busy),
    .sweep_row (sweep_row),
    .wr        (wr_m),
    .rd        (rd_m),
    .bank_cmd  (bank_cmd),
    .rd_pbnk   (rd_pbnk)
  );

  bank_array u_bank_array (
    .clk      (clk),
    .rst      (rst),
    .bank_cmd (bank_cmd),
    .rd_pbnk  (rd_pbnk),
    .rd_en    (rd_en),
    .rd_vld   (rd_vld),
    .rd_data  (rd_data)
  );

endmodule

// File: testbench/mem_1r1w_props.sv
module mem_1r1w_props
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
(
  input logic                clk,
  input logic                rst,
  input logic                ready,
  input logic                rd_en,
  input logic                wr_en,
  input logic                rd_vld,
  input logic [bit_pbnk-1:0] rd_pbnk,
  input logic [bit_pbnk-1:0] rd_free,
  input bank_cmd_vec_t       bank_cmd
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [num_pbnk-1:0] cmd_en;
  int                  assert_errors = 0;

  always_comb begin
    for (int p = 0; p < num_pbnk; p++) begin
      cmd_en[p] = bank_cmd[p].en;
    end
  end

  // read and write each own a bank
  bank_per_req: assert property (@(posedge clk) disable iff (rst)
    $countones(cmd_en) == int'(rd_en) + int'(wr_en))
    else begin $error("read and write share a bank"); assert_errors++; end
  ready_holds: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
    else begin $error("ready fell after rising"); assert_errors++; end
  vld_after_rd: assert property (@(posedge clk) disable iff (rst) rd_en |-> ##2 rd_vld)
    else begin $error("rd_vld missing two cycles after read"); assert_errors++; end
  vld_from_rd: assert property (@(posedge clk) disable iff (rst) rd_vld |-> $past(rd_en, 2))
    else begin $error("rd_vld without a read"); assert_errors++; end
  rd_not_free: assert property (@(posedge clk) disable iff (rst) rd_en |-> rd_pbnk != rd_free)
    else begin $error("read hit the free bank"); assert_errors++; end

endmodule

// File: testbench/tb_mem_1r1w.sv
module tb_mem_1r1w
  import mem_cfg_pkg::*;
  import mem_port_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clk_period  = 8;
  localparam int rst_cycles  = 4;
  localparam int num_addr    = 1 << bit_addr;
  localparam int num_rand    = 400;
  localparam int drain       = 4;
  localparam int test_cycles = 3 * num_addr + 8 + 4 * num_vrow + num_rand + 4 * drain;
  localparam int run_cycles  = rst_cycles + num_vrow + 2 + test_cycles + 50;

  typedef struct packed {
    logic [31:0]      due;                      // compare cycle
    logic [width-1:0] data;
  } exp_rd_t;

  bit               clk;
  logic             rst;
  logic             ready;
  wr_req_t          wr;
  rd_req_t          rd;
  logic             rd_vld;
  logic [width-1:0] rd_data;
  logic [width-1:0] shadow [num_addr];
  exp_rd_t          exp_q [$];
  logic [15:0]      lfsr = 16'd62734;
  int               cycle;
  int               checks;
  int               data_errors;
  int               ctrl_errors;
  bit               ready_seen;

  mem_1r1w_top u_mem_1r1w_top (
    .clk     (clk),
    .rst     (rst),
    .ready   (ready),
    .wr      (wr),
    .rd      (rd),
    .rd_vld  (rd_vld),
    .rd_data (rd_data)
  );

  bind mem_1r1w_top mem_1r1w_props u_mem_1r1w_props (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .rd_en    (rd_en),
    .wr_en    (wr_m.en),
    .rd_vld   (rd_vld),
    .rd_pbnk  (rd_pbnk),
    .rd_free  (u_remap_table.rd_map.free),
    .bank_cmd (bank_cmd)
  );

  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = out ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);   // galois step
    return out;
  endfunction

  function automatic logic [31:0] random_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[30:0], lfsr_bit()};
    end
    return val;
  endfunction

  // expected read is the contents before this cycle's write
  function automatic logic [width-1:0] ref_read(mem_addr_u addr);
    return shadow[addr.flat];
  endfunction

  task automatic drive(input logic re, input logic [bit_addr-1:0] ra, input logic we,
                       input logic [bit_addr-1:0] wa, input logic [width-1:0] wd);
    rd = '{en: re, addr: ra};
    wr = '{en: we, addr: wa, data: wd};
    @(posedge clk);
    #1;
  endtask

  task automatic idle(int n);
    repeat (n) drive(1'b0, '0, 1'b0, '0, '0);
  endtask

  initial begin
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(run_cycles * clk_period);
    $display("watchdog expired after %0d cycles, run did not finish", run_cycles);
    $display("Testbench failed");
    $finish;
  end

  always @(negedge clk) begin : compare
    exp_rd_t head;
    if (rst && ready !== 1'b0) begin
      ctrl_errors++;
      $display("Fail at %0t: ready expected 0 got %b", $time, ready);
    end
    if (ready_seen && ready !== 1'b1) begin
      ctrl_errors++;
      $display("Fail at %0t: ready expected 1 got %b", $time, ready);
    end
    ready_seen = ready_seen || (ready === 1'b1);
    if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
      head = exp_q.pop_front();
      checks++;
      if (rd_vld !== 1'b1) begin
        ctrl_errors++;
        $display("Fail at %0t: rd_vld expected 1 got %b", $time, rd_vld);
      end else if (rd_data !== head.data) begin
        data_errors++;
        $display("Fail at %0t: rd_data expected %h got %h", $time, head.data, rd_data);
      end
    end else if (rd_vld !== 1'b0) begin
      ctrl_errors++;
      $display("Fail at %0t: rd_vld expected 0 got %b", $time, rd_vld);
    end
    if (ready === 1'b1 && rd.en) begin
      exp_q.push_back('{due: cycle + 2, data: ref_read(rd.addr)});   // answered 2 edges on
    end
    if (ready === 1'b1 && wr.en) begin
      shadow[wr.addr.flat] = wr.data;
    end
    cycle++;
  end

  initial begin
    logic [bit_addr-1:0] ra;
    logic [bit_addr-1:0] wa;
    logic [width-1:0]    wd;
    logic                re;
    logic                we;
    int                  waited;
    int                  asrt;
    rst = 1'b1;
    rd  = '0;
    wr  = '0;
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst    = 1'b0;
    waited = 0;
    while (ready !== 1'b1 && waited <= num_vrow + 2) begin
      ra = bit_addr'(random_bits(bit_addr));
      wd = width'(random_bits(width));
      drive(1'b1, ra, 1'b1, ra, wd);             // all dropped before ready
      waited++;
    end
    if (ready !== 1'b1 || waited < num_vrow) begin
      ctrl_errors++;
      $display("ready came up after %0d cycles, outside the sweep window", waited);
    end
    for (int i = 0; i < num_addr; i++) begin
      drive(1'b0, '0, 1'b1, bit_addr'(i), width'(random_bits(width)));
    end
    for (int i = 0; i < num_addr; i++) begin
      drive(1'b1, bit_addr'(i), 1'b0, '0, '0);
    end
    idle(drain);
    for (int i = 0; i < 4; i++) begin
      ra = bit_addr'(random_bits(bit_addr));
      drive(1'b1, ra, 1'b1, ra, width'(random_bits(width)));
      drive(1'b1, ra, 1'b0, '0, '0);
    end
    idle(drain);
    // same vbank on read and write, forces redirects on every row
    for (int rep = 0; rep < 4; rep++) begin
      for (int r = 0; r < num_vrow; r++) begin
        ra = {bit_vbnk'(r + rep), bit_vrow'(r)};
        wa = {bit_vbnk'(r + rep), bit_vrow'(r + 1)};
        drive(1'b1, ra, 1'b1, wa, width'(random_bits(width)));
      end
    end
    for (int i = 0; i < num_addr; i++) begin
      drive(1'b1, bit_addr'(i), 1'b0, '0, '0);
    end
    idle(drain);
    for (int i = 0; i < num_rand; i++) begin
      re = lfsr_bit();
      ra = bit_addr'(random_bits(bit_addr));
      we = lfsr_bit();
      wa = bit_addr'(random_bits(bit_addr));
      wd = width'(random_bits(width));
      drive(re, ra, we, wa, wd);
    end
    idle(drain);
    if (exp_q.size() != 0) begin
      ctrl_errors++;
      $display("%0d reads never returned data", exp_q.size());
    end
    asrt = u_mem_1r1w_top.u_mem_1r1w_props.assert_errors;
    $display("reads checked %0d, data errors %0d, control errors %0d, assertion errors %0d",
             checks, data_errors, ctrl_errors, asrt);
    if (data_errors == 0 && ctrl_errors == 0 && asrt == 0 && checks > 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/mem_cfg_pkg.sv
verilog/mem_port_pkg.sv
verilog/bank_sram.sv
verilog/row_sweep_counter.sv
verilog/init_ctrl.sv
verilog/remap_table.sv
verilog/bank_array.sv
verilog/mem_1r1w_top.sv
testbench/mem_1r1w_props.sv
testbench/tb_mem_1r1w.sv

// File: Bender.yml
package:
  name: mem_1r1w

sources:
  - files:
      - verilog/mem_cfg_pkg.sv
      - verilog/mem_port_pkg.sv
      - verilog/bank_sram.sv
      - verilog/row_sweep_counter.sv
      - verilog/init_ctrl.sv
      - verilog/remap_table.sv
      - verilog/bank_array.sv
      - verilog/mem_1r1w_top.sv
  - target: test
    files:
      - testbench/mem_1r1w_props.sv
      - testbench/tb_mem_1r1w.sv
